// File: design/pipe_pkg.sv
package pipe_pkg;

    // ####################
    // datapath widths
    // ####################

    localparam int xlen = 32;           // word width.

    // register files.
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;     // per file, int and fp alike.

endpackage

// File: design/isa_pkg.sv
package isa_pkg;

    // ####################
    // major opcodes
    // ####################

    localparam logic [6:0] opc_load     = 7'b0000011;
    localparam logic [6:0] opc_store    = 7'b0100011;
    localparam logic [6:0] opc_branch   = 7'b1100011;
    localparam logic [6:0] opc_jal      = 7'b1101111;
    localparam logic [6:0] opc_jalr     = 7'b1100111;
    localparam logic [6:0] opc_lui      = 7'b0110111;
    localparam logic [6:0] opc_auipc    = 7'b0010111;
    localparam logic [6:0] opc_arith_i  = 7'b0010011;
    localparam logic [6:0] opc_arith    = 7'b0110011;

    // single precision extension.
    localparam logic [6:0] opc_fp_load  = 7'b0000111;    // flw.
    localparam logic [6:0] opc_fp_store = 7'b0100111;    // fsw.
    localparam logic [6:0] opc_fp_op    = 7'b1010011;
    localparam logic [6:0] opc_fp_fma   = 7'b1000011;    // fmadd.s.

    // ####################
    // immediate formats
    // ####################

    typedef enum logic [2:0] {
        imm_i,
        imm_s,
        imm_b,
        imm_u,
        imm_j
    } imm_sel_t;

    // ####################
    // instruction source
    // ####################

    // pc bit 30 picks bios over imem.
    localparam int         pc_src_bit    = 30;
    localparam logic [0:0] inst_src_imem = 1'b0;
    localparam logic [0:0] inst_src_bios = 1'b1;

endpackage

// File: design/reg_file.sv
module reg_file #(
    parameter type data_t   = logic [pipe_pkg::xlen-1:0],
    parameter int  num_read = 2,
    parameter bit  zero_reg = 1'b0
) (
    input  logic                              clk,
    input  logic                              id_reg_rst,
    input  logic                              we,
    input  logic [pipe_pkg::reg_addr_w-1:0]   wa,
    input  data_t                             wd,
    input  logic [pipe_pkg::reg_addr_w-1:0]   ra [num_read],
    output data_t                             rd [num_read]
);
    import pipe_pkg::*;

    data_t regs [num_regs];

    // write port, visible from the next cycle.
    always_ff @(posedge clk) begin
        if (we && !(zero_reg && (wa == '0))) begin
            regs[wa] <= wd;
        end
        if (zero_reg && id_reg_rst) begin
            regs[0] <= '0;      // x0 starts at zero.
        end
    end

    // async read ports.
    always_comb begin
        for (int i = 0; i < num_read; i++) begin
            rd[i] = regs[ra[i]];
        end
    end

    // ####################
    // checks
    // ####################

    // a write aimed at x0 must not leak into later reads.
    if (zero_reg) begin : g_zero_chk
        for (genvar i = 0; i < num_read; i++) begin : g_port
            zero_read : assert property (
                @(posedge clk) disable iff (id_reg_rst)
                (we && (wa == '0)) ##1 (ra[i] == '0) |-> (rd[i] == '0)
            ) else $error("reg_file: index 0 read nonzero on port %0d", i);
        end
    end

endmodule

// File: design/imm_gen.sv
module imm_gen (
    input  logic [pipe_pkg::xlen-1:0]  inst,
    input  isa_pkg::imm_sel_t          sel,
    output logic [pipe_pkg::xlen-1:0]  imm
);
    import pipe_pkg::*;
    import isa_pkg::*;

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (sel)
            imm_i: begin
                imm = {{(xlen-11){sign}}, inst[30:20]};
            end
            imm_s: begin
                imm = {{(xlen-11){sign}}, inst[30:25], inst[11:7]};
            end
            imm_b: begin
                // halfword aligned offset.
                imm = {{(xlen-12){sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            imm_u: begin
                imm = {inst[31:12], 12'b0};     // upper 20, low bits zero.
            end
            imm_j: begin
                imm = {{(xlen-20){sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// File: design/id_control.sv
module id_control (
    input  logic [pipe_pkg::xlen-1:0]  inst,
    input  logic [pipe_pkg::xlen-1:0]  ex_inst,
    input  logic                       fpu_busy,
    output isa_pkg::imm_sel_t          imm_sel,
    output logic                       stall,
    output logic                       hold,
    output logic                       fpu_valid,
    output logic                       fwd_rs1,
    output logic                       fwd_rs2
);
    import pipe_pkg::*;
    import isa_pkg::*;

    logic [6:0]            opc;
    logic [6:0]            ex_opc;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] ex_rd;
    logic                  uses_rs1;
    logic                  uses_rs2;
    logic                  fp_compute;
    logic                  ex_is_load;
    logic                  ex_writes_int;

    assign opc    = inst[6:0];
    assign ex_opc = ex_inst[6:0];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign ex_rd  = ex_inst[11:7];

    // ####################
    // decode
    // ####################

    always_comb begin
        imm_sel  = imm_i;
        uses_rs1 = !(opc inside {opc_lui, opc_auipc, opc_jal});
        uses_rs2 = opc inside {opc_store, opc_branch, opc_arith,
                               opc_fp_store, opc_fp_op, opc_fp_fma};
        case (opc)
            opc_store, opc_fp_store: imm_sel = imm_s;
            opc_branch:              imm_sel = imm_b;
            opc_lui, opc_auipc:      imm_sel = imm_u;
            opc_jal:                 imm_sel = imm_j;
            default:                 imm_sel = imm_i;
        endcase
    end

    assign fp_compute    = (opc == opc_fp_op) || (opc == opc_fp_fma);
    assign ex_is_load    = (ex_opc == opc_load) || (ex_opc == opc_fp_load);
    assign ex_writes_int = ex_opc inside {opc_lui, opc_auipc, opc_jal, opc_jalr,
                                          opc_arith_i, opc_arith};

    // ####################
    // hazards
    // ####################

    assign stall = ex_is_load && (ex_rd != '0) &&
                   ((uses_rs1 && (ex_rd == rs1)) || (uses_rs2 && (ex_rd == rs2)));

    assign hold = fp_compute && fpu_busy;   // fpu still on the last op.

    assign fwd_rs1 = ex_writes_int && (ex_rd != '0) && (ex_rd == rs1);
    assign fwd_rs2 = ex_writes_int && (ex_rd != '0) && (ex_rd == rs2);

    // issue only when the stage actually advances.
    assign fpu_valid = fp_compute && !fpu_busy && !stall;

endmodule

// File: design/id_ex_reg.sv
module id_ex_reg (
    input  logic                       clk,
    input  logic                       id_reg_rst,
    input  logic                       stall,
    input  logic                       hold,
    input  logic                       ex_flush,
    input  logic                       wb_flush,
    input  logic [pipe_pkg::xlen-1:0]  pc,
    input  logic [pipe_pkg::xlen-1:0]  inst,
    input  logic [pipe_pkg::xlen-1:0]  rd1,
    input  logic [pipe_pkg::xlen-1:0]  rd2,
    input  logic [pipe_pkg::xlen-1:0]  fd1,
    input  logic [pipe_pkg::xlen-1:0]  fd2,
    input  logic [pipe_pkg::xlen-1:0]  fd3,
    input  logic [pipe_pkg::xlen-1:0]  imm,
    input  logic                       target_taken,
    input  logic                       fwd_rs1,
    input  logic                       fwd_rs2,
    input  logic                       fpu_valid,
    output logic [pipe_pkg::xlen-1:0]  ex_pc,
    output logic [pipe_pkg::xlen-1:0]  ex_inst,
    output logic [pipe_pkg::xlen-1:0]  ex_rd1,
    output logic [pipe_pkg::xlen-1:0]  ex_rd2,
    output logic [pipe_pkg::xlen-1:0]  ex_fd1,
    output logic [pipe_pkg::xlen-1:0]  ex_fd2,
    output logic [pipe_pkg::xlen-1:0]  ex_fd3,
    output logic [pipe_pkg::xlen-1:0]  ex_imm,
    output logic                       ex_target_taken,
    output logic                       ex_fwd_rs1,
    output logic                       ex_fwd_rs2,
    output logic                       ex_fpu_valid,
    output logic                       ex_id_ex_stall
);
    import pipe_pkg::*;

    logic bubble;

    // hold wins over any flush.
    assign bubble = !hold && (stall || ex_flush || wb_flush || id_reg_rst);

    always_ff @(posedge clk) begin
        if (bubble) begin
            {ex_pc, ex_inst, ex_rd1, ex_rd2} <= '0;
            {ex_fd1, ex_fd2, ex_fd3, ex_imm} <= '0;
            {ex_target_taken, ex_fwd_rs1, ex_fwd_rs2} <= '0;
        end else if (!hold) begin
            ex_pc           <= pc;
            ex_inst         <= inst;
            ex_rd1          <= rd1;
            ex_rd2          <= rd2;
            ex_fd1          <= fd1;
            ex_fd2          <= fd2;
            ex_fd3          <= fd3;
            ex_imm          <= imm;
            ex_target_taken <= target_taken;
            ex_fwd_rs1      <= fwd_rs1;
            ex_fwd_rs2      <= fwd_rs2;
        end
    end

    always_ff @(posedge clk) begin
        if (id_reg_rst) begin
            ex_fpu_valid   <= 1'b0;
            ex_id_ex_stall <= 1'b0;
        end else begin
            ex_fpu_valid   <= fpu_valid;
            ex_id_ex_stall <= hold;     // tells ex the bundle is stale.
        end
    end

    ex_hold_stable : assert property (
        @(posedge clk) disable iff (id_reg_rst)
        hold |=> $stable({ex_pc, ex_inst, ex_rd1, ex_rd2, ex_fd1, ex_fd2, ex_fd3,
                          ex_imm, ex_target_taken, ex_fwd_rs1, ex_fwd_rs2})
    ) else $error("id_ex_reg: ex bundle changed under hold");

endmodule

// File: design/id_stage.sv
module id_stage (
    input  logic                       clk,
    input  logic                       id_reg_rst,

    input  logic [pipe_pkg::xlen-1:0]  id_pc,
    input  logic [pipe_pkg::xlen-1:0]  id_bios_inst,
    input  logic [pipe_pkg::xlen-1:0]  id_imem_inst,
    input  logic                       id_target_taken,

    input  logic                       ex_fpu_busy,
    input  logic                       ex_flush,

    input  logic [pipe_pkg::xlen-1:0]  wb_inst,
    input  logic [pipe_pkg::xlen-1:0]  wb_fp_inst,
    input  logic [pipe_pkg::xlen-1:0]  wb_wdata,
    input  logic [pipe_pkg::xlen-1:0]  wb_fp_wdata,
    input  logic                       wb_flush,
    input  logic                       wb_regwen,
    input  logic                       wb_fp_regwen,

    output logic                       ex_id_ex_stall,
    output logic [pipe_pkg::xlen-1:0]  ex_pc,
    output logic [pipe_pkg::xlen-1:0]  ex_rd1,
    output logic [pipe_pkg::xlen-1:0]  ex_rd2,
    output logic [pipe_pkg::xlen-1:0]  ex_fd1,
    output logic [pipe_pkg::xlen-1:0]  ex_fd2,
    output logic [pipe_pkg::xlen-1:0]  ex_fd3,
    output logic [pipe_pkg::xlen-1:0]  ex_imm,
    output logic [pipe_pkg::xlen-1:0]  ex_inst,
    output logic                       ex_target_taken,
    output logic                       ex_fpu_valid,
    output logic                       ex_fwd_rs1,
    output logic                       ex_fwd_rs2,

    output logic                       id_stall
);
    import pipe_pkg::*;
    import isa_pkg::*;

    logic [xlen-1:0]       id_inst;
    logic [reg_addr_w-1:0] fp_wa;
    logic [reg_addr_w-1:0] int_ra [2];
    logic [xlen-1:0]       int_rd [2];
    logic [reg_addr_w-1:0] fp_ra [3];
    logic [xlen-1:0]       fp_rd [3];
    logic [xlen-1:0]       imm;
    imm_sel_t              imm_sel;
    logic                  stall;
    logic                  hold;
    logic                  fpu_valid;
    logic                  fwd_rs1;
    logic                  fwd_rs2;

    // ####################
    // fetch word select
    // ####################

    always_comb begin
        case (id_pc[pc_src_bit])
            inst_src_bios: id_inst = id_bios_inst;
            inst_src_imem: id_inst = id_imem_inst;
            default:       id_inst = id_imem_inst;
        endcase
    end

    // ####################
    // register files
    // ####################

    assign int_ra[0] = id_inst[19:15];
    assign int_ra[1] = id_inst[24:20];
    assign fp_ra[0]  = id_inst[19:15];
    assign fp_ra[1]  = id_inst[24:20];
    assign fp_ra[2]  = id_inst[31:27];     // rs3 for fma.

    // flw results come back on the integer wb path.
    assign fp_wa = (wb_inst[6:0] == opc_fp_load) ? wb_inst[11:7] : wb_fp_inst[11:7];

    reg_file #(
        .data_t   (logic [xlen-1:0]),
        .num_read (2),
        .zero_reg (1'b1)
    ) int_regs (
        .clk        (clk),
        .id_reg_rst (id_reg_rst),
        .we         (wb_regwen),
        .wa         (wb_inst[11:7]),
        .wd         (wb_wdata),
        .ra         (int_ra),
        .rd         (int_rd)
    );

    reg_file #(
        .data_t   (logic [xlen-1:0]),
        .num_read (3),
        .zero_reg (1'b0)
    ) fp_regs (
        .clk        (clk),
        .id_reg_rst (id_reg_rst),
        .we         (wb_fp_regwen),
        .wa         (fp_wa),
        .wd         (wb_fp_wdata),
        .ra         (fp_ra),
        .rd         (fp_rd)
    );

    // ####################
    // decode and hazards
    // ####################

    imm_gen imm_gen (
        .inst (id_inst),
        .sel  (imm_sel),
        .imm  (imm)
    );

    id_control id_control (
        .inst      (id_inst),
        .ex_inst   (ex_inst),
        .fpu_busy  (ex_fpu_busy),
        .imm_sel   (imm_sel),
        .stall     (stall),
        .hold      (hold),
        .fpu_valid (fpu_valid),
        .fwd_rs1   (fwd_rs1),
        .fwd_rs2   (fwd_rs2)
    );

    assign id_stall = stall || hold;    // fetch freezes.

    id_ex_reg id_ex_reg (
        .clk             (clk),
        .id_reg_rst      (id_reg_rst),
        .stall           (stall),
        .hold            (hold),
        .ex_flush        (ex_flush),
        .wb_flush        (wb_flush),
        .pc              (id_pc),
        .inst            (id_inst),
        .rd1             (int_rd[0]),
        .rd2             (int_rd[1]),
        .fd1             (fp_rd[0]),
        .fd2             (fp_rd[1]),
        .fd3             (fp_rd[2]),
        .imm             (imm),
        .target_taken    (id_target_taken),
        .fwd_rs1         (fwd_rs1),
        .fwd_rs2         (fwd_rs2),
        .fpu_valid       (fpu_valid),
        .ex_pc           (ex_pc),
        .ex_inst         (ex_inst),
        .ex_rd1          (ex_rd1),
        .ex_rd2          (ex_rd2),
        .ex_fd1          (ex_fd1),
        .ex_fd2          (ex_fd2),
        .ex_fd3          (ex_fd3),
        .ex_imm          (ex_imm),
        .ex_target_taken (ex_target_taken),
        .ex_fwd_rs1      (ex_fwd_rs1),
        .ex_fwd_rs2      (ex_fwd_rs2),
        .ex_fpu_valid    (ex_fpu_valid),
        .ex_id_ex_stall  (ex_id_ex_stall)
    );

endmodule

// File: verif/id_stage_tb.sv
module id_stage_tb;
    import pipe_pkg::*;
    import isa_pkg::*;

    // six tests of about 40 cycles, plus reset and some margin.
    localparam int reset_cycles = 10;
    localparam int test_cycles  = 40;
    localparam int max_cycles   = reset_cycles + 6 * test_cycles + 150;
    localparam logic [31:0] nop = 32'h0000_0013;    // addi x0, x0, 0.

    logic clk, id_reg_rst;
    logic [xlen-1:0] id_pc, id_bios_inst, id_imem_inst;
    logic id_target_taken, ex_fpu_busy, ex_flush, wb_flush;
    logic [xlen-1:0] wb_inst, wb_fp_inst, wb_wdata, wb_fp_wdata;
    logic wb_regwen, wb_fp_regwen;
    logic [xlen-1:0] ex_pc, ex_inst, ex_rd1, ex_rd2, ex_fd1, ex_fd2, ex_fd3, ex_imm;
    logic ex_id_ex_stall, ex_target_taken, ex_fpu_valid, ex_fwd_rs1, ex_fwd_rs2, id_stall;

    logic [xlen-1:0] int_model [num_regs];
    logic [xlen-1:0] fp_model [num_regs];
    logic [31:0]     lcg_state = 32'h82da_512f;
    int              errors = 0;
    int              checks = 0;
    int              cycles = 0;
    string           test_name = "none";

    id_stage UUT (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // ####################
    // helpers
    // ####################

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] encode(input logic [6:0] opc, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [6:0] top);
        return {top, rs2, rs1, 3'b000, rd, opc};
    endfunction

    // standard RISC-V immediate placement, chosen by opcode.
    function automatic logic [31:0] ref_imm(input logic [31:0] inst);
        case (inst[6:0])
            opc_store, opc_fp_store: return {{20{inst[31]}}, inst[31:25], inst[11:7]};
            opc_branch: return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            opc_lui, opc_auipc: return {inst[31:12], 12'h000};
            opc_jal: return {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default: return {{20{inst[31]}}, inst[31:20]};
        endcase
    endfunction

    task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("CHECK FAILED [%s] %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // the unselected source carries a decoy word.
    task automatic drive_inst(input logic [31:0] pc, input logic [31:0] inst);
        id_pc = pc;
        id_bios_inst = pc[pc_src_bit] ? inst : ~inst;
        id_imem_inst = pc[pc_src_bit] ? ~inst : inst;
    endtask

    task automatic fill_regs();
        for (int i = 0; i < num_regs; i++) begin
            wb_regwen = 1'b1;
            wb_fp_regwen = 1'b1;
            wb_inst = encode(opc_arith, i, 5'd0, 5'd0, 7'd0);
            wb_fp_inst = encode(opc_fp_op, i, 5'd0, 5'd0, 7'd0);
            wb_wdata = next_rand();
            wb_fp_wdata = next_rand();
            int_model[i] = (i == 0) ? '0 : wb_wdata;    // x0 stays zero.
            fp_model[i] = wb_fp_wdata;
            tick();
        end
        wb_regwen = 1'b0;
        wb_fp_regwen = 1'b0;
    endtask

    // flw result, address from wb_inst.
    task automatic write_fp_load(input logic [4:0] idx, input logic [31:0] val);
        wb_inst = encode(opc_fp_load, idx, 5'd1, 5'd0, 7'd0);
        wb_fp_inst = encode(opc_fp_op, 5'd20, 5'd0, 5'd0, 7'd0);
        wb_fp_wdata = val;
        wb_fp_regwen = 1'b1;
        fp_model[idx] = val;
        tick();
        wb_fp_regwen = 1'b0;
    endtask

    // fpu result, address from wb_fp_inst.
    task automatic write_fp_result(input logic [4:0] idx, input logic [31:0] val);
        wb_inst = encode(opc_arith, 5'd21, 5'd0, 5'd0, 7'd0);
        wb_fp_inst = encode(opc_fp_op, idx, 5'd0, 5'd0, 7'd0);
        wb_fp_wdata = val;
        wb_fp_regwen = 1'b1;
        fp_model[idx] = val;
        tick();
        wb_fp_regwen = 1'b0;
    endtask

    // ####################
    // tests
    // ####################

    task automatic test_reset();
        test_name = "reset";
        expect_eq("ex_pc", '0, ex_pc);
        expect_eq("ex_inst", '0, ex_inst);
        expect_eq("ex_rd1", '0, ex_rd1);
        expect_eq("ex_rd2", '0, ex_rd2);
        expect_eq("ex_fd1", '0, ex_fd1);
        expect_eq("ex_fd2", '0, ex_fd2);
        expect_eq("ex_fd3", '0, ex_fd3);
        expect_eq("ex_imm", '0, ex_imm);
        expect_eq("ex_target_taken", '0, ex_target_taken);
        expect_eq("ex_fwd_rs1", '0, ex_fwd_rs1);
        expect_eq("ex_fwd_rs2", '0, ex_fwd_rs2);
        expect_eq("ex_fpu_valid", '0, ex_fpu_valid);
        expect_eq("ex_id_ex_stall", '0, ex_id_ex_stall);
        expect_eq("id_stall", '0, id_stall);
    endtask

    task automatic test_int_read();
        logic [31:0] inst;
        test_name = "int_read";
        fill_regs();
        inst = encode(opc_arith, 5'd5, 5'd7, 5'd9, 7'd0);
        drive_inst(32'h4000_0010, inst);    // bios.
        id_target_taken = 1'b1;
        tick();
        expect_eq("ex_inst bios", inst, ex_inst);
        expect_eq("ex_pc bios", 32'h4000_0010, ex_pc);
        expect_eq("ex_rd1 bios", int_model[7], ex_rd1);
        expect_eq("ex_rd2 bios", int_model[9], ex_rd2);
        expect_eq("ex_target_taken", 1'b1, ex_target_taken);
        id_target_taken = 1'b0;
        inst = encode(opc_arith, 5'd6, 5'd0, 5'd3, 7'd0);
        drive_inst(32'h0000_0104, inst);    // imem.
        tick();
        expect_eq("ex_inst imem", inst, ex_inst);
        expect_eq("ex_pc imem", 32'h0000_0104, ex_pc);
        expect_eq("ex_rd1 x0", '0, ex_rd1);
        expect_eq("ex_rd2 imem", int_model[3], ex_rd2);
    endtask

    task automatic test_imm();
        logic [6:0]  opcs [5];
        logic [31:0] bits;
        logic [31:0] inst;
        test_name = "imm";
        opcs = '{opc_arith_i, opc_store, opc_branch, opc_lui, opc_jal};
        foreach (opcs[i]) begin
            bits = next_rand();
            inst = {bits[31:7], opcs[i]};
            drive_inst(32'h0000_0200 + 4 * i, inst);
            tick();
            expect_eq($sformatf("ex_imm opc %b", opcs[i]), ref_imm(inst), ex_imm);
        end
        drive_inst(32'h0, nop);
        tick();
    endtask

    task automatic test_load_use();
        logic [31:0] inst;
        test_name = "load_use";
        drive_inst(32'h0000_0300, encode(opc_load, 5'd6, 5'd2, 5'd0, 7'd0));
        tick();
        inst = encode(opc_arith, 5'd8, 5'd6, 5'd3, 7'd0);
        drive_inst(32'h0000_0304, inst);
        #1;
        expect_eq("id_stall on use", 1'b1, id_stall);
        tick();
        expect_eq("ex_inst bubble", '0, ex_inst);
        expect_eq("ex_pc bubble", '0, ex_pc);
        expect_eq("id_stall after bubble", 1'b0, id_stall);
        tick();
        expect_eq("ex_inst user", inst, ex_inst);
        expect_eq("ex_rd1 user", int_model[6], ex_rd1);
        // alu producer then consumers.
        drive_inst(32'h0000_0308, encode(opc_arith_i, 5'd10, 5'd1, 5'd0, 7'd0));
        tick();
        drive_inst(32'h0000_030c, encode(opc_arith, 5'd11, 5'd4, 5'd10, 7'd0));
        tick();
        expect_eq("ex_fwd_rs1 on rs2 use", 1'b0, ex_fwd_rs1);
        expect_eq("ex_fwd_rs2", 1'b1, ex_fwd_rs2);
        drive_inst(32'h0000_0310, encode(opc_arith, 5'd12, 5'd11, 5'd0, 7'd0));
        tick();
        expect_eq("ex_fwd_rs1", 1'b1, ex_fwd_rs1);
        expect_eq("ex_fwd_rs2 on rs1 use", 1'b0, ex_fwd_rs2);
        drive_inst(32'h0, nop);
        tick();
    endtask

    task automatic test_fp_path();
        logic [31:0] fma;
        logic [31:0] fadd;
        test_name = "fp_path";
        write_fp_load(5'd3, next_rand());
        write_fp_result(5'd4, next_rand());
        write_fp_result(5'd5, next_rand());
        fma = encode(opc_fp_fma, 5'd7, 5'd3, 5'd4, {5'd5, 2'b00});
        drive_inst(32'h0000_0400, fma);
        tick();
        expect_eq("ex_fd1", fp_model[3], ex_fd1);
        expect_eq("ex_fd2", fp_model[4], ex_fd2);
        expect_eq("ex_fd3", fp_model[5], ex_fd3);
        expect_eq("ex_fpu_valid fma", 1'b1, ex_fpu_valid);
        fadd = encode(opc_fp_op, 5'd8, 5'd3, 5'd4, 7'd0);
        drive_inst(32'h0000_0404, fadd);
        ex_fpu_busy = 1'b1;
        #1;
        expect_eq("id_stall busy", 1'b1, id_stall);
        repeat (2) begin
            tick();
            expect_eq("ex_inst held", fma, ex_inst);
            expect_eq("ex_pc held", 32'h0000_0400, ex_pc);
            expect_eq("ex_fd1 held", fp_model[3], ex_fd1);
            expect_eq("ex_imm held", ref_imm(fma), ex_imm);
            expect_eq("ex_id_ex_stall", 1'b1, ex_id_ex_stall);
            expect_eq("ex_fpu_valid busy", 1'b0, ex_fpu_valid);
        end
        ex_fpu_busy = 1'b0;
        tick();
        expect_eq("ex_inst fadd", fadd, ex_inst);
        expect_eq("ex_fpu_valid fadd", 1'b1, ex_fpu_valid);
        expect_eq("ex_id_ex_stall released", 1'b0, ex_id_ex_stall);
        drive_inst(32'h0, nop);
        tick();
    endtask

    task automatic test_flush();
        logic [31:0] inst;
        test_name = "flush";
        drive_inst(32'h0000_0500, encode(opc_arith, 5'd13, 5'd1, 5'd2, 7'd0));
        ex_flush = 1'b1;
        tick();
        expect_eq("ex_inst ex_flush", '0, ex_inst);
        expect_eq("ex_pc ex_flush", '0, ex_pc);
        expect_eq("ex_rd1 ex_flush", '0, ex_rd1);
        ex_flush = 1'b0;
        inst = encode(opc_arith, 5'd14, 5'd15, 5'd16, 7'h20);
        drive_inst(32'h0000_0504, inst);
        wb_flush = 1'b1;
        tick();
        expect_eq("ex_inst wb_flush", '0, ex_inst);
        expect_eq("ex_pc wb_flush", '0, ex_pc);
        wb_flush = 1'b0;
        tick();
        expect_eq("ex_inst after flush", inst, ex_inst);
        expect_eq("ex_rd1 after flush", int_model[15], ex_rd1);
    endtask

    // ####################
    // run
    // ####################

    initial begin
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", max_cycles);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        id_reg_rst = 1'b1;
        drive_inst(32'h0, 32'h0);
        {id_target_taken, ex_fpu_busy, ex_flush, wb_flush} = '0;
        {wb_inst, wb_fp_inst, wb_wdata, wb_fp_wdata} = '0;
        {wb_regwen, wb_fp_regwen} = '0;
        repeat (reset_cycles) tick();
        id_reg_rst = 1'b0;
        test_reset();
        test_int_read();
        test_imm();
        test_load_use();
        test_fp_path();
        test_flush();
        $display("id_stage_tb: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: flist.f
design/pipe_pkg.sv
design/isa_pkg.sv
design/reg_file.sv
design/imm_gen.sv
design/id_control.sv
design/id_ex_reg.sv
design/id_stage.sv
verif/id_stage_tb.sv

// File: Bender.yml
package:
  name: id_stage

sources:
  - design/pipe_pkg.sv
  - design/isa_pkg.sv
  - design/reg_file.sv
  - design/imm_gen.sv
  - design/id_control.sv
  - design/id_ex_reg.sv
  - design/id_stage.sv
  - target: test
    files:
      - verif/id_stage_tb.sv
